/* source/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    // number of stored bytes.
    localparam int mem_depth = 2048;

    // full byte address, three page bits above eight word bits.
    localparam int addr_width = 11;

    // upper nibble of a control byte that selects this device.
    localparam logic [3:0] device_code = 4'b1010;

    // flops in the bus line synchronizer.
    localparam int sync_stages = 2;

    // control FSM states.
    // idle waits for a start condition.
    // ctrl_byte expects the control byte after a start.
    // word_addr and write_data follow a write control byte.
    // read_data lasts while the slave transmits.
    // ignore holds off until the next stop or start.
    typedef enum logic [2:0] {
        idle,
        ctrl_byte,
        word_addr,
        write_data,
        read_data,
        ignore
    } ctrl_state_t;

endpackage

`default_nettype wire

/* source/bus_decode.sv */
`default_nettype none

module bus_decode (
    input  logic       sda,
    input  logic       rst_n,
    input  logic       scl,
    input  logic       sdi,
    output logic       start_seen,
    output logic       stop_seen,
    output logic       scl_fall,
    output logic       byte_done,
    output logic [7:0] rx_byte,
    output logic       ack_slot
);
    import eeprom_pkg::*;

    logic [sync_stages-1:0] scl_sync;
    logic [sync_stages-1:0] sdi_sync;
    logic                   scl_s;
    logic                   sdi_s;
    logic                   scl_q;
    logic                   sdi_q;
    logic                   scl_rise;
    logic [3:0]             bit_cnt;

    assign scl_s = scl_sync[sync_stages-1];
    assign sdi_s = sdi_sync[sync_stages-1];

    // the idle bus is high on both lines.
    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            scl_sync <= '1;
            sdi_sync <= '1;
            scl_q    <= 1'b1;
            sdi_q    <= 1'b1;
        end
        else
        begin
            scl_sync <= {scl_sync[sync_stages-2:0], scl};
            sdi_sync <= {sdi_sync[sync_stages-2:0], sdi};
            scl_q    <= scl_s;
            sdi_q    <= sdi_s;
        end
    end

    // edge and condition strobes, registered one cycle past the synchronizer.
    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            start_seen <= 1'b0;
            stop_seen  <= 1'b0;
            scl_rise   <= 1'b0;
            scl_fall   <= 1'b0;
        end
        else
        begin
            start_seen <= scl_s && scl_q && sdi_q && !sdi_s;
            stop_seen  <= scl_s && scl_q && !sdi_q && sdi_s;
            scl_rise   <= scl_s && !scl_q;
            scl_fall   <= !scl_s && scl_q;
        end
    end

    // bit slots 0 to 7 carry data, slot 8 is the acknowledge.
    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            bit_cnt   <= '0;
            byte_done <= 1'b0;
            ack_slot  <= 1'b0;
        end
        else
        begin
            byte_done <= scl_rise && (bit_cnt == 4'd7);
            if (start_seen || stop_seen)
            begin
                bit_cnt  <= '0;
                ack_slot <= 1'b0;
            end
            else
            begin
                if (scl_rise)
                    bit_cnt <= (bit_cnt == 4'd8) ? 4'd0 : bit_cnt + 4'd1;
                if (scl_fall)
                    ack_slot <= (bit_cnt == 4'd8); // slot opens after the 8th bit.
            end
        end
    end

    // the ninth rise shifts in the acknowledge bit too, so rx_byte[0] holds it afterwards.
    always_ff @(posedge sda)
    begin
        if (scl_rise)
            rx_byte <= {rx_byte[6:0], sdi_s};
    end

endmodule

`default_nettype wire

/* source/eeprom_control.sv */
`default_nettype none

module eeprom_control (
    input  logic                              sda,
    input  logic                              rst_n,
    input  logic                              start_seen,
    input  logic                              stop_seen,
    input  logic                              byte_done,
    input  logic [7:0]                        rx_byte,
    input  logic                              ack_slot,
    output logic                              wr_en,
    output logic                              rd_en,
    output logic [eeprom_pkg::addr_width-1:0] addr,
    output logic [7:0]                        wr_data,
    output logic                              rd_ready,
    output logic                              ack_pull,
    output logic                              read_active
);
    import eeprom_pkg::*;

    ctrl_state_t state;
    logic [2:0]  page_q;
    logic [7:0]  word_q;
    logic        ack_slot_q;
    logic        slot_end;
    logic        dev_match;

    assign dev_match = (rx_byte[7:4] == device_code);
    assign slot_end  = ack_slot_q && !ack_slot;

    // a read control byte reads the array on its own byte_done cycle.
    assign rd_en = byte_done && (state == ctrl_byte) && dev_match && rx_byte[0];
    assign addr  = rd_en ? {rx_byte[3:1], word_q} : {page_q, word_q};

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            state       <= idle;
            ack_pull    <= 1'b0;
            read_active <= 1'b0;
            wr_en       <= 1'b0;
            rd_ready    <= 1'b0;
            ack_slot_q  <= 1'b0;
        end
        else
        begin
            ack_slot_q <= ack_slot;
            rd_ready   <= rd_en;  // rd_data is valid now.
            wr_en      <= 1'b0;
            if (slot_end)
                ack_pull <= 1'b0;
            if (stop_seen)
            begin
                state       <= idle;
                ack_pull    <= 1'b0;
                read_active <= 1'b0;
            end
            else if (start_seen)
            begin
                state       <= ctrl_byte;
                ack_pull    <= 1'b0;
                read_active <= 1'b0;
            end
            else if (byte_done)
            begin
                case (state)
                    ctrl_byte:
                    begin
                        if (!dev_match)
                            state <= ignore;  // another device on the bus.
                        else if (rx_byte[0])
                        begin
                            state       <= read_data;
                            read_active <= 1'b1;
                            ack_pull    <= 1'b1;
                        end
                        else
                        begin
                            state    <= word_addr;
                            ack_pull <= 1'b1;
                        end
                    end
                    word_addr:
                    begin
                        state    <= write_data;
                        ack_pull <= 1'b1;
                    end
                    write_data:
                    begin
                        wr_en    <= 1'b1;
                        ack_pull <= 1'b1;
                        state    <= ignore; // No page write.
                    end
                    default:
                    begin
                        state <= state;
                    end
                endcase
            end
            else if ((state == read_data) && slot_end && !ack_pull)
            begin
                // the master answered the data byte; a NACK ends cleanly.
                read_active <= 1'b0;
                state       <= rx_byte[0] ? idle : ignore;
            end
        end
    end

    // address and data bytes carry no reset.
    always_ff @(posedge sda)
    begin
        if (byte_done && (state == ctrl_byte) && dev_match && !rx_byte[0])
            page_q <= rx_byte[3:1];
        if (byte_done && (state == word_addr))
            word_q <= rx_byte;
        if (byte_done && (state == write_data))
            wr_data <= rx_byte;
    end

endmodule

`default_nettype wire

/* source/read_shifter.sv */
`default_nettype none

module read_shifter (
    input  logic       sda,
    input  logic       rst_n,
    input  logic       scl_fall,
    input  logic       load_read,
    input  logic [7:0] rd_data,
    input  logic       read_active,
    input  logic       ack_pull,
    input  logic       ack_slot,
    output logic       sdo_low
);

    logic [7:0] shreg;
    logic [3:0] bits_left;
    logic       ack_start;
    logic       send_bit;

    // ack_pull is still set when its slot begins, ack_slot rises only after this fall.
    assign ack_start = ack_pull && !ack_slot;
    assign send_bit  = read_active && (bits_left != 4'd0) && !ack_start;

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            sdo_low   <= 1'b0;
            bits_left <= '0;
        end
        else
        begin
            if (load_read)
                bits_left <= 4'd8;
            else if (scl_fall && send_bit)
                bits_left <= bits_left - 4'd1;
            if (scl_fall)
            begin
                if (ack_start)
                    sdo_low <= 1'b1;
                else if (send_bit)
                    sdo_low <= ~shreg[7]; // pull low for a zero bit.
                else
                    sdo_low <= 1'b0;
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (load_read)
            shreg <= rd_data;
        else if (scl_fall && send_bit)
            shreg <= {shreg[6:0], 1'b0};
    end

endmodule

`default_nettype wire

/* source/eeprom_array.sv */
`default_nettype none

module eeprom_array (
    input  logic                              sda,
    input  logic                              wr_en,
    input  logic                              rd_en,
    input  logic [eeprom_pkg::addr_width-1:0] addr,
    input  logic [7:0]                        wr_data,
    output logic [7:0]                        rd_data
);
    import eeprom_pkg::*;

    logic [7:0] mem [mem_depth];

    always_ff @(posedge sda)
    begin
        if (wr_en)
            mem[addr] <= wr_data;
        if (rd_en)
            rd_data <= mem[addr]; // one cycle read latency.
    end

endmodule

`default_nettype wire

/* source/i2c_eeprom.sv */
`default_nettype none

module i2c_eeprom (
    input  logic sda,
    input  logic rst_n,
    input  logic scl,
    input  logic sdi,
    output logic sdo_low
);
    import eeprom_pkg::*;

    logic                  start_seen;
    logic                  stop_seen;
    logic                  scl_fall;
    logic                  byte_done;
    logic [7:0]            rx_byte;
    logic                  ack_slot;
    logic                  wr_en;
    logic                  rd_en;
    logic [addr_width-1:0] addr;
    logic [7:0]            wr_data;
    logic [7:0]            rd_data;
    logic                  load_read;
    logic                  ack_pull;
    logic                  read_active;

    bus_decode u_decode (
        .sda        (sda),
        .rst_n      (rst_n),
        .scl        (scl),
        .sdi        (sdi),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .scl_fall   (scl_fall),
        .byte_done  (byte_done),
        .rx_byte    (rx_byte),
        .ack_slot   (ack_slot)
    );

    eeprom_control u_control (
        .sda         (sda),
        .rst_n       (rst_n),
        .start_seen  (start_seen),
        .stop_seen   (stop_seen),
        .byte_done   (byte_done),
        .rx_byte     (rx_byte),
        .ack_slot    (ack_slot),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .addr        (addr),
        .wr_data     (wr_data),
        .rd_ready    (load_read),
        .ack_pull    (ack_pull),
        .read_active (read_active)
    );

    eeprom_array u_array (
        .sda     (sda),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

    read_shifter u_shifter (
        .sda         (sda),
        .rst_n       (rst_n),
        .scl_fall    (scl_fall),
        .load_read   (load_read),
        .rd_data     (rd_data),
        .read_active (read_active),
        .ack_pull    (ack_pull),
        .ack_slot    (ack_slot),
        .sdo_low     (sdo_low)
    );

endmodule

`default_nettype wire

/* dv/i2c_eeprom_assert.sv */
`default_nettype none

module i2c_eeprom_assert (
    input logic sda,
    input logic rst_n,
    input logic scl,
    input logic sdo_low,
    input logic start_seen,
    input logic stop_seen
);

    assert property (@(posedge sda) !rst_n |=> !sdo_low)
        else $error("sdo_low is pulling after reset");

    assert property (@(posedge sda) disable iff (!rst_n) !(start_seen && stop_seen))
        else $error("start and stop strobes in the same cycle");

    // the data line may only move while the bus clock is low.
    assert property (@(posedge sda) disable iff (!rst_n)
        (sdo_low != $past(sdo_low)) |-> !scl)
        else $error("sdo_low changed outside the scl low phase");

endmodule

bind i2c_eeprom i2c_eeprom_assert u_assert (
    .sda        (sda),
    .rst_n      (rst_n),
    .scl        (scl),
    .sdo_low    (sdo_low),
    .start_seen (start_seen),
    .stop_seen  (stop_seen)
);

`default_nettype wire

/* dv/tb_i2c_eeprom.sv */
`default_nettype none

module tb_i2c_eeprom;

    localparam int half_period = 8;       // sda cycles per scl phase.
    localparam int drain_limit = 100;
    localparam int run_limit   = 4000000;

    logic        sda;
    logic        rst_n;
    logic        scl;
    logic        m_sda;
    logic        sdi;
    logic        sdo_low;
    logic [7:0]  ref_mem [2048];
    logic        written [2048];
    logic [15:0] lfsr;
    logic [7:0]  exp_q [$];
    logic [7:0]  got_q [$];
    string       what_q [$];
    int          errors;
    int          checks;
    int          err_mark;

    assign sdi = m_sda & ~sdo_low; // open-drain wired AND.

    i2c_eeprom dut (
        .sda     (sda),
        .rst_n   (rst_n),
        .scl     (scl),
        .sdi     (sdi),
        .sdo_low (sdo_low)
    );

    initial
    begin
        sda = 1'b0;
        forever #5 sda = ~sda;
    end

    initial
    begin
        #(run_limit);
        $display("simulation ran past its time limit, bus master is stuck");
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic expected_ack(input logic [7:0] ctrl);
        return ctrl[7:4] == 4'b1010;
    endfunction

    function automatic logic [7:0] expected_read(input logic [10:0] a);
        return ref_mem[a];
    endfunction

    // 16-bit Fibonacci LFSR with taps 16 14 13 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    // the compare process takes one queued result per clock.
    always @(posedge sda)
    begin
        if (got_q.size() > 0)
        begin
            checks++;
            if (got_q[0] !== exp_q[0])
            begin
                $display("FAILED at %0t: %s expected %02h got %02h",
                         $time, what_q[0], exp_q[0], got_q[0]);
                errors++;
            end
            void'(got_q.pop_front());
            void'(exp_q.pop_front());
            void'(what_q.pop_front());
        end
    end

    task automatic expect_val(input logic [7:0] e, input logic [7:0] g, input string what);
        exp_q.push_back(e);
        got_q.push_back(g);
        what_q.push_back(what);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sda);
        #1;
    endtask

    task automatic bus_start;
        m_sda = 1'b1;
        wait_cycles(half_period);
        scl = 1'b1;
        wait_cycles(half_period);
        m_sda = 1'b0;                    // sdi falls while scl is high.
        wait_cycles(half_period);
        scl = 1'b0;
    endtask

    task automatic bus_stop;
        m_sda = 1'b0;
        wait_cycles(half_period);
        scl = 1'b1;
        wait_cycles(half_period);
        m_sda = 1'b1;
        wait_cycles(half_period);
    endtask

    task automatic send_bit(input logic b);
        m_sda = b;
        wait_cycles(half_period);
        scl = 1'b1;
        wait_cycles(half_period);
        scl = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b, output logic ack);
        for (int i = 7; i >= 0; i--)
            send_bit(b[i]);
        m_sda = 1'b1;
        wait_cycles(half_period);
        scl = 1'b1;
        wait_cycles(half_period / 2);
        ack = sdo_low;                   // sampled mid way through the ninth high phase.
        wait_cycles(half_period / 2);
        scl = 1'b0;
    endtask

    // reads one byte and answers with a NACK.
    task automatic read_byte(output logic [7:0] d);
        m_sda = 1'b1;
        for (int i = 7; i >= 0; i--)
        begin
            wait_cycles(half_period);
            scl = 1'b1;
            wait_cycles(half_period / 2);
            d[i] = sdi;
            wait_cycles(half_period / 2);
            scl = 1'b0;
        end
        send_bit(1'b1);
    endtask

    task automatic send_checked(input logic [7:0] b, input logic e, input string what);
        logic ack;
        send_byte(b, ack);
        expect_val({7'd0, e}, {7'd0, ack}, what);
    endtask

    task automatic write_mem(input logic [10:0] a, input logic [7:0] d);
        logic [7:0] ctrl;
        ctrl = {4'b1010, a[10:8], 1'b0};
        bus_start();
        send_checked(ctrl, expected_ack(ctrl), "write control ack");
        send_checked(a[7:0], 1'b1, "word address ack");
        send_checked(d, 1'b1, "data ack");
        bus_stop();
        ref_mem[a] = d;
        written[a] = 1'b1;
    endtask

    task automatic read_mem(input logic [10:0] a);
        logic [7:0] ctrl;
        logic [7:0] d;
        ctrl = {4'b1010, a[10:8], 1'b0};
        bus_start();
        send_checked(ctrl, 1'b1, "dummy write control ack");
        send_checked(a[7:0], 1'b1, "read word address ack");
        bus_start();
        send_checked(ctrl | 8'h01, 1'b1, "read control ack");
        read_byte(d);
        bus_stop();
        expect_val(expected_read(a), d, $sformatf("read at %03h", a));
    endtask

    task automatic finish_test(input string name);
        int n;
        n = 0;
        while (got_q.size() != 0 && n < drain_limit)
        begin
            @(posedge sda);
            n++;
        end
        #1;
        if (got_q.size() != 0)
        begin
            $display("compare queue never emptied after test %s", name);
            errors++;
        end
        $display("test %s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial
    begin
        logic [15:0] r;
        logic [7:0]  d;
        logic [10:0] a;
        rst_n    = 1'b0;
        scl      = 1'b1;
        m_sda    = 1'b1;
        lfsr     = 16'd6;
        errors   = 0;
        checks   = 0;
        err_mark = 0;
        for (int i = 0; i < 2048; i++)
            written[i] = 1'b0;
        wait_cycles(8);
        rst_n = 1'b1;
        wait_cycles(half_period);

        write_mem(11'h53c, 8'ha7);
        read_mem(11'h53c);
        finish_test("write_then_read");

        bus_start();
        send_checked(8'h94, expected_ack(8'h94), "foreign write control");
        send_checked(8'h3c, 1'b0, "foreign address byte");
        bus_stop();
        bus_start();
        send_checked(8'hb5, expected_ack(8'hb5), "foreign read control");
        read_byte(d);
        bus_stop();
        expect_val(8'hff, d, "released line on foreign read");
        finish_test("foreign_device_code");

        write_mem(11'h240, 8'h11);
        write_mem(11'h640, 8'hee);
        read_mem(11'h240);
        read_mem(11'h640);
        finish_test("page_bits");

        write_mem(11'h1c7, 8'h5a);
        bus_start();
        send_checked(8'ha2, 1'b1, "aborted write control ack");
        send_checked(8'hc7, 1'b1, "aborted word address ack");
        for (int i = 0; i < 4; i++)
            send_bit(1'b0);
        bus_stop();                     // stop lands in the middle of the data byte.
        read_mem(11'h1c7);
        finish_test("stop_mid_byte");

        // a narrow address window so that reads often hit written bytes.
        for (int n = 0; n < 40; n++)
        begin
            take_bits(3, r);
            a[10:8] = r[2:0];
            take_bits(3, r);
            a[7:0] = {5'h15, r[2:0]};
            take_bits(1, r);
            if (r[0] == 1'b0 || !written[a])
            begin
                take_bits(8, r);
                write_mem(a, r[7:0]);
            end
            else
                read_mem(a);
        end
        finish_test("random_traffic");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/eeprom_pkg.sv
source/bus_decode.sv
source/eeprom_control.sv
source/read_shifter.sv
source/eeprom_array.sv
source/i2c_eeprom.sv
dv/i2c_eeprom_assert.sv
dv/tb_i2c_eeprom.sv

/* run.sh */
#!/bin/sh
# Build and run the EEPROM testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_i2c_eeprom -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
